// File: tb.f
+incdir+include
hdl/synth_pkg.sv
hdl/phase_mem_if.sv
hdl/adc_spi_receiver.sv
hdl/sine_rom.sv
hdl/phase_memory.sv
hdl/harmonic_sequencer.sv
hdl/dac_spi_transmitter.sv
hdl/additive_synth_top.sv
test/tb_additive_synth.sv

// File: Makefile
# Verilator build of the additive synthesizer testbench
VERILATOR ?= verilator
TOP ?= tb_additive_synth
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILE_LIST)))
HEADERS := $(wildcard include/*.svh)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, a header or the file list changes
$(SIM): $(FILE_LIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: test/stimulus_input.txt
# Columns: command, value, number of DAC frames checked after the command
# FREQ sends a 16 bit word, SHORT a 12 bit frame, RUN value is a fixed code or 0 for none
RUN 0 4
FREQ 3000 6
SHORT 255 4
FREQ 20000 6
FREQ 60000 6
FREQ 0 5
FREQ 6500 2
FREQ 0 2
RUN 32768 3

// File: include/synth_tb_model.svh
`ifndef SYNTH_TB_MODEL_SVH
`define SYNTH_TB_MODEL_SVH

`default_nettype none

localparam real PI = 3.141592653589793;

// Model phase per harmonic, starts at zero like the phase RAM
int unsigned model_phase [HARMONICS];
// Frequency of the next computed sample, and the one after a new word
int unsigned freq_now;
int unsigned freq_next;

// Wait for a number of rising edges, then step past them to drive
task automatic step_cycles(input int count);
	repeat (count) @(posedge adc_data_received);
	#2;
endtask

// Full scale sine, rounded to nearest
function automatic int sine_value(input int unsigned index);
	real sample;
	sample = 32767.0 * $sin(2.0 * PI * index / LUT_SIZE);
	if (sample >= 0.0) begin
		return $rtoi(sample + 0.5);
	end
	return $rtoi(sample - 0.5);
endfunction

// One sample period of the synthesizer
task automatic advance_model(output logic [15:0] code);
	int sum;
	int unsigned p;
	sum = 0;
	for (int h = 1; h <= HARMONICS; h++) begin
		// Harmonic h advances by h times the frequency, wrapped at the sample rate
		p = (model_phase[h - 1] + h * freq_now) % SAMPLE_RATE;
		model_phase[h - 1] = p;
		sum += sine_value(p >> PHASE_SHIFT);
	end
	// Average of the harmonics in offset binary
	code = 16'(32768 + (sum >>> HARMONIC_SHIFT));
	// A word sent during this period applies from the next one
	freq_now = freq_next;
endtask

// SPI master, MSB first, half period of two system clocks
task automatic send_spi_frame(input logic [15:0] value, input int bits);
	step_cycles(1);
	adc_spi_nss = 1'b0;
	for (int i = bits - 1; i >= 0; i--) begin
		adc_spi_data = value[i];
		step_cycles(2);
		adc_spi_clock = 1'b1;
		step_cycles(2);
		adc_spi_clock = 1'b0;
	end
	step_cycles(2);
	adc_spi_nss = 1'b1;
	adc_spi_data = 1'b0;
	// Receiver strobes three cycles after nss rises
	step_cycles(4);
endtask

// Collect one DAC frame, sampled at falling system edges where all is stable
task automatic capture_dac_frame(output logic [23:0] word, output int bits);
	logic prev_clock;
	word = '0;
	bits = 0;
	prev_clock = 1'b0;
	@(negedge adc_data_received);
	while (dac_spi_cs) begin
		@(negedge adc_data_received);
	end
	while (!dac_spi_cs) begin
		// DAC takes a bit on each rising SPI clock
		if (dac_spi_clock && !prev_clock) begin
			word = {word[22:0], dac_spi_data};
			bits++;
		end
		prev_clock = dac_spi_clock;
		@(negedge adc_data_received);
	end
endtask

`default_nettype wire

`endif

// File: test/tb_additive_synth.sv
`timescale 1ns/100ps
`default_nettype none

module tb_additive_synth;

	localparam int SAMPLE_RATE = 48000;
	localparam int SAMPLE_INTERVAL = 200;
	localparam int LUT_SIZE = 1500;
	localparam int PHASE_SHIFT = 5;
	localparam int HARMONIC_SHIFT = 2;
	localparam int HARMONICS = 2 ** HARMONIC_SHIFT;
	localparam int DEFAULT_FREQUENCY = 1000;
	localparam int CLK_PERIOD = 20;
	// Write and update channel A
	localparam logic [7:0] DAC_CMD = 8'h31;
	localparam string STIMULUS_FILE = "test/stimulus_input.txt";

	logic adc_data_received;
	logic reset;
	logic adc_spi_nss;
	logic adc_spi_clock;
	logic adc_spi_data;
	logic dac_spi_cs;
	logic dac_spi_clock;
	logic dac_spi_data;

	// Stimulus records
	string cmd_q[$];
	int value_q[$];
	int frames_q[$];
	int frame_index;
	longint watchdog_ns;
	logic watchdog_armed;

	`include "synth_tb_model.svh"

	additive_synth_top #(.SAMPLE_INTERVAL(SAMPLE_INTERVAL)) dut (
		.adc_data_received(adc_data_received),
		.reset(reset),
		.adc_spi_nss(adc_spi_nss),
		.adc_spi_clock(adc_spi_clock),
		.adc_spi_data(adc_spi_data),
		.dac_spi_cs(dac_spi_cs),
		.dac_spi_clock(dac_spi_clock),
		.dac_spi_data(dac_spi_data)
	);

	initial begin
		adc_data_received = 1'b0;
		forever #(CLK_PERIOD / 2) adc_data_received = ~adc_data_received;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic report_error(input string msg);
		abort_run($sformatf("ERROR at %0d ns: %s", $time, msg));
	endtask

	// Capture frames and compare them with the model
	// A fixed_code of 0 leaves out the fixed value check
	task automatic check_frames(input int count, input int fixed_code);
		logic [23:0] word;
		logic [15:0] expected;
		int bits;
		for (int i = 0; i < count; i++) begin
			capture_dac_frame(word, bits);
			advance_model(expected);
			assert (bits == 24) else
				report_error($sformatf("frame %0d has %0d bits", frame_index, bits));
			assert (word[23:16] == DAC_CMD) else
				report_error($sformatf("frame %0d command %h", frame_index, word[23:16]));
			assert (word[15:0] == expected) else
				report_error($sformatf("frame %0d code %0d, expected %0d",
					frame_index, word[15:0], expected));
			assert (fixed_code == 0 || word[15:0] == 16'(fixed_code)) else
				report_error($sformatf("frame %0d code %0d, file expects %0d",
					frame_index, word[15:0], fixed_code));
			frame_index++;
		end
	endtask

	// Limit follows the number of frames in the stimulus file
	initial begin
		wait (watchdog_armed);
		#(watchdog_ns);
		abort_run("Timeout: DAC frames stopped arriving before the test finished");
	end

	initial begin
		int fd;
		int scanned;
		int value;
		int frames;
		int total_frames;
		string line;
		string cmd;
		reset = 1'b1;
		adc_spi_nss = 1'b1;
		adc_spi_clock = 1'b0;
		adc_spi_data = 1'b0;
		watchdog_armed = 1'b0;
		watchdog_ns = 0;
		frame_index = 0;
		freq_now = DEFAULT_FREQUENCY;
		freq_next = DEFAULT_FREQUENCY;
		for (int h = 0; h < HARMONICS; h++) begin
			model_phase[h] = 0;
		end

		fd = $fopen(STIMULUS_FILE, "r");
		if (fd == 0) begin
			abort_run({"Could not open the stimulus file ", STIMULUS_FILE});
		end
		total_frames = 0;
		while ($fgets(line, fd) != 0) begin
			// Comment lines open with a hash
			if (line.len() > 0 && line.getc(0) != "#") begin
				scanned = $sscanf(line, "%s %d %d", cmd, value, frames);
				if (scanned == 3) begin
					cmd_q.push_back(cmd);
					value_q.push_back(value);
					frames_q.push_back(frames);
					total_frames += frames;
				end
			end
		end
		$fclose(fd);
		// Margin covers reset and the first period
		watchdog_ns = longint'(total_frames + 4) * SAMPLE_INTERVAL * CLK_PERIOD;
		watchdog_armed = 1'b1;

		step_cycles(2);
		reset = 1'b0;
		assert (dac_spi_cs === 1'b1 && dac_spi_clock === 1'b0 && dac_spi_data === 1'b0) else
			report_error("DAC SPI lines not idle after reset");

		// Every SPI frame goes out right after a DAC frame ends
		foreach (cmd_q[i]) begin
			case (cmd_q[i])
				"FREQ": begin
					send_spi_frame(16'(value_q[i]), 16);
					freq_next = value_q[i];
				end
				"SHORT": send_spi_frame(16'(value_q[i]), 12);
				"RUN": ;
				default: abort_run({"Unknown command in stimulus file: ", cmd_q[i]});
			endcase
			check_frames(frames_q[i], cmd_q[i] == "RUN" ? value_q[i] : 0);
		end

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/additive_synth_top.sv
`timescale 1ns/100ps
`default_nettype none

module additive_synth_top #(
	parameter int SAMPLE_RATE = 48000,
	parameter int SAMPLE_INTERVAL = 1500,
	parameter int LUT_SIZE = 1500,
	parameter int PHASE_SHIFT = 5,
	parameter int HARMONIC_SHIFT = 2,
	parameter int DEFAULT_FREQUENCY = 1000
) (
	input logic adc_data_received,
	input logic reset,
	input logic adc_spi_nss,
	input logic adc_spi_clock,
	input logic adc_spi_data,
	output logic dac_spi_cs,
	output logic dac_spi_clock,
	output logic dac_spi_data
);

	// Receiver to sequencer
	logic [synth_pkg::SAMPLE_WIDTH-1:0] frequency;
	logic frequency_valid;
	// Sequencer to sine table
	logic [10:0] lut_addr;
	logic signed [synth_pkg::SAMPLE_WIDTH-1:0] lut_value;
	// Sequencer to transmitter
	logic [synth_pkg::DAC_FRAME_WIDTH-1:0] dac_word;
	logic dac_send;

	// Phase memory bus, one word per harmonic
	phase_mem_if #(.ADDR_WIDTH(HARMONIC_SHIFT)) phase_bus ();

	adc_spi_receiver #(
		.DEFAULT_FREQUENCY(DEFAULT_FREQUENCY)
	) receiver (
		.adc_data_received(adc_data_received),
		.reset(reset),
		.adc_spi_nss(adc_spi_nss),
		.adc_spi_clock(adc_spi_clock),
		.adc_spi_data(adc_spi_data),
		.frequency(frequency),
		.frequency_valid(frequency_valid)
	);

	sine_rom #(.LUT_SIZE(LUT_SIZE)) sine_table (
		.adc_data_received(adc_data_received),
		.addr(lut_addr),
		.value(lut_value)
	);

	phase_memory #(.HARMONIC_SHIFT(HARMONIC_SHIFT)) phases (
		.adc_data_received(adc_data_received),
		.mem(phase_bus.memory)
	);

	harmonic_sequencer #(
		.SAMPLE_RATE(SAMPLE_RATE),
		.SAMPLE_INTERVAL(SAMPLE_INTERVAL),
		.PHASE_SHIFT(PHASE_SHIFT),
		.HARMONIC_SHIFT(HARMONIC_SHIFT)
	) sequencer (
		.adc_data_received(adc_data_received),
		.reset(reset),
		.frequency(frequency),
		.frequency_valid(frequency_valid),
		.lut_value(lut_value),
		.lut_addr(lut_addr),
		.dac_word(dac_word),
		.dac_send(dac_send),
		.mem(phase_bus.controller)
	);

	dac_spi_transmitter transmitter (
		.adc_data_received(adc_data_received),
		.reset(reset),
		.dac_word(dac_word),
		.dac_send(dac_send),
		.dac_spi_cs(dac_spi_cs),
		.dac_spi_clock(dac_spi_clock),
		.dac_spi_data(dac_spi_data)
	);

endmodule

`default_nettype wire

// File: hdl/dac_spi_transmitter.sv
`timescale 1ns/100ps
`default_nettype none

module dac_spi_transmitter (
	input logic adc_data_received,
	input logic reset,
	input logic [synth_pkg::DAC_FRAME_WIDTH-1:0] dac_word,
	input logic dac_send,
	output logic dac_spi_cs,
	output logic dac_spi_clock,
	output logic dac_spi_data
);

	localparam int COUNT_WIDTH = $clog2(synth_pkg::DAC_FRAME_WIDTH + 1);
	localparam logic [COUNT_WIDTH-1:0] LAST_BIT = COUNT_WIDTH'(synth_pkg::DAC_FRAME_WIDTH);

	// Zeros shift in behind the word, data idles low
	logic [synth_pkg::DAC_FRAME_WIDTH-1:0] shift_reg;
	// Bits fully clocked out so far
	logic [COUNT_WIDTH-1:0] bit_count;

	// MSB first
	assign dac_spi_data = shift_reg[synth_pkg::DAC_FRAME_WIDTH-1];

	always_ff @(posedge adc_data_received or posedge reset) begin
		if (reset) begin
			dac_spi_cs <= 1'b1;
			dac_spi_clock <= 1'b0;
			shift_reg <= '0;
			bit_count <= '0;
		end else if (dac_spi_cs) begin
			// Idle, wait for a frame
			if (dac_send) begin
				dac_spi_cs <= 1'b0;
				shift_reg <= dac_word;
				bit_count <= '0;
			end
		end else if (bit_count == LAST_BIT) begin
			// One cycle after the last falling edge
			dac_spi_cs <= 1'b1;
		end else if (!dac_spi_clock) begin
			// DAC samples on this rising edge
			dac_spi_clock <= 1'b1;
		end else begin
			// Falling edge, present the next bit
			dac_spi_clock <= 1'b0;
			shift_reg <= {shift_reg[synth_pkg::DAC_FRAME_WIDTH-2:0], 1'b0};
			bit_count <= bit_count + 1'b1;
		end
	end

	// Sample interval must exceed one frame
	assert property (@(posedge adc_data_received) disable iff (reset)
		dac_send |-> dac_spi_cs);

endmodule

`default_nettype wire

// File: hdl/harmonic_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module harmonic_sequencer #(
	parameter int SAMPLE_RATE = 48000,
	parameter int SAMPLE_INTERVAL = 1500,
	parameter int PHASE_SHIFT = 5,
	parameter int HARMONIC_SHIFT = 2
) (
	input logic adc_data_received,
	input logic reset,
	input logic [synth_pkg::SAMPLE_WIDTH-1:0] frequency,
	input logic frequency_valid,
	input logic signed [synth_pkg::SAMPLE_WIDTH-1:0] lut_value,
	output logic [10:0] lut_addr,
	output logic [synth_pkg::DAC_FRAME_WIDTH-1:0] dac_word,
	output logic dac_send,
	phase_mem_if.controller mem
);

	// Room for phase plus the largest harmonic step
	localparam int PHASE_WIDTH = synth_pkg::SAMPLE_WIDTH + HARMONIC_SHIFT + 1;
	localparam int SUM_WIDTH = synth_pkg::SAMPLE_WIDTH + HARMONIC_SHIFT;
	localparam int COUNT_WIDTH = $clog2(SAMPLE_INTERVAL);
	localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(SAMPLE_INTERVAL - 1);
	localparam logic [PHASE_WIDTH-1:0] WRAP_VALUE = PHASE_WIDTH'(SAMPLE_RATE);

	synth_pkg::seq_state_t state;
	logic [COUNT_WIDTH-1:0] period_count;
	logic [HARMONIC_SHIFT-1:0] harmonic;
	logic update_pending;
	logic [synth_pkg::SAMPLE_WIDTH-1:0] active_frequency;
	logic [synth_pkg::SAMPLE_WIDTH-1:0] next_frequency;
	// h times the frequency for the current harmonic
	logic [PHASE_WIDTH-1:0] step;
	logic [PHASE_WIDTH-1:0] phase;
	logic signed [SUM_WIDTH-1:0] sample_sum;
	logic signed [SUM_WIDTH-1:0] scaled_sum;
	logic [synth_pkg::SAMPLE_WIDTH-1:0] dac_code;
	logic loop_start;
	logic last_count;

	assign loop_start = (state == synth_pkg::IDLE || state == synth_pkg::WAIT_PERIOD)
		&& period_count == '0;
	assign last_count = period_count == LAST_COUNT;
	// New word only applies at a period start
	assign next_frequency = update_pending ? frequency : active_frequency;
	// Divide by the harmonic count, then offset binary
	assign scaled_sum = sample_sum >>> HARMONIC_SHIFT;
	assign dac_code = scaled_sum[synth_pkg::SAMPLE_WIDTH-1:0] + 16'h8000;
	assign mem.addr = harmonic;
	assign mem.write_data = phase[synth_pkg::SAMPLE_WIDTH-1:0];

	// Sample period timer
	always_ff @(posedge adc_data_received or posedge reset) begin
		if (reset) begin
			period_count <= '0;
		end else if (last_count) begin
			period_count <= '0;
		end else begin
			period_count <= period_count + 1'b1;
		end
	end

	// Harmonic loop control
	always_ff @(posedge adc_data_received or posedge reset) begin
		if (reset) begin
			state <= synth_pkg::IDLE;
			harmonic <= '0;
			mem.write <= 1'b0;
			lut_addr <= '0;
			// Take the receiver's reset word on the first period
			update_pending <= 1'b1;
			dac_send <= 1'b0;
		end else begin
			dac_send <= last_count;
			if (frequency_valid) begin
				update_pending <= 1'b1;
			end else if (loop_start) begin
				update_pending <= 1'b0;
			end

			case (state)
				synth_pkg::IDLE, synth_pkg::WAIT_PERIOD: begin
					if (loop_start) begin
						harmonic <= '0;
						state <= synth_pkg::READ_PHASE;
					end
				end
				synth_pkg::READ_PHASE: state <= synth_pkg::ADVANCE;
				synth_pkg::ADVANCE: state <= synth_pkg::WRAP;
				synth_pkg::WRAP: begin
					// Phase in range, store it and address the table
					if (phase < WRAP_VALUE) begin
						mem.write <= 1'b1;
						lut_addr <= 11'(phase >> PHASE_SHIFT);
						state <= synth_pkg::LOOKUP;
					end
				end
				synth_pkg::LOOKUP: begin
					mem.write <= 1'b0;
					state <= synth_pkg::ACCUMULATE;
				end
				synth_pkg::ACCUMULATE: begin
					if (harmonic == '1) begin
						state <= synth_pkg::WAIT_PERIOD;
					end else begin
						harmonic <= harmonic + 1'b1;
						state <= synth_pkg::READ_PHASE;
					end
				end
				default: state <= synth_pkg::IDLE;
			endcase
		end
	end

	// Phase arithmetic, sum and output word
	always_ff @(posedge adc_data_received) begin
		if (loop_start) begin
			active_frequency <= next_frequency;
			step <= PHASE_WIDTH'(next_frequency);
			sample_sum <= '0;
		end
		case (state)
			synth_pkg::ADVANCE: phase <= PHASE_WIDTH'(mem.read_data) + step;
			synth_pkg::WRAP: begin
				// One subtraction per cycle
				if (phase >= WRAP_VALUE) begin
					phase <= phase - WRAP_VALUE;
				end
			end
			synth_pkg::ACCUMULATE: begin
				sample_sum <= sample_sum + SUM_WIDTH'(lut_value);
				step <= step + PHASE_WIDTH'(active_frequency);
			end
			default: ;
		endcase
		if (last_count) begin
			dac_word <= {synth_pkg::DAC_CMD_CHANNEL_A, dac_code};
		end
	end

	// Loop has to fit inside the sample interval
	assert property (@(posedge adc_data_received) disable iff (reset)
		last_count |-> state inside {synth_pkg::IDLE, synth_pkg::WAIT_PERIOD});

	assert property (@(posedge adc_data_received) disable iff (reset)
		dac_send |=> !dac_send);

endmodule

`default_nettype wire

// File: hdl/phase_memory.sv
`timescale 1ns/100ps
`default_nettype none

module phase_memory #(
	parameter int HARMONIC_SHIFT = 2
) (
	input logic adc_data_received,
	phase_mem_if.memory mem
);

	localparam int HARMONICS = 2 ** HARMONIC_SHIFT;

	// One running phase per harmonic, all start at zero
	logic [synth_pkg::SAMPLE_WIDTH-1:0] phases [HARMONICS] = '{default: '0};

	// Single port, read returns the old word on a write
	always_ff @(posedge adc_data_received) begin
		if (mem.write) begin
			phases[mem.addr] <= mem.write_data;
		end
		mem.read_data <= phases[mem.addr];
	end

endmodule

`default_nettype wire

// File: hdl/sine_rom.sv
`timescale 1ns/100ps
`default_nettype none

module sine_rom #(
	parameter int LUT_SIZE = 1500
) (
	input logic adc_data_received,
	input logic [10:0] addr,
	output logic signed [synth_pkg::SAMPLE_WIDTH-1:0] value
);

	localparam real PI = 3.141592653589793;

	// One full sine cycle at full signed scale
	logic signed [synth_pkg::SAMPLE_WIDTH-1:0] sine_table [LUT_SIZE];

	// Filled at elaboration and rounded to nearest
	initial begin
		real sample;
		for (int i = 0; i < LUT_SIZE; i++) begin
			sample = 32767.0 * $sin(2.0 * PI * i / LUT_SIZE);
			if (sample >= 0.0) begin
				sine_table[i] = synth_pkg::SAMPLE_WIDTH'($rtoi(sample + 0.5));
			end else begin
				sine_table[i] = synth_pkg::SAMPLE_WIDTH'($rtoi(sample - 0.5));
			end
		end
	end

	// Registered read with one cycle latency
	always_ff @(posedge adc_data_received) begin
		value <= sine_table[addr];
	end

	// Phase scaling must keep the address inside the table
	assert property (@(posedge adc_data_received) addr < LUT_SIZE);

endmodule

`default_nettype wire

// File: hdl/adc_spi_receiver.sv
`timescale 1ns/100ps
`default_nettype none

module adc_spi_receiver #(
	parameter int DEFAULT_FREQUENCY = 1000
) (
	input logic adc_data_received,
	input logic reset,
	input logic adc_spi_nss,
	input logic adc_spi_clock,
	input logic adc_spi_data,
	output logic [synth_pkg::SAMPLE_WIDTH-1:0] frequency,
	output logic frequency_valid
);

	localparam int COUNT_WIDTH = $clog2(synth_pkg::SAMPLE_WIDTH) + 1;

	// Two stage synchronizers, data delayed alongside to stay aligned
	logic [1:0] nss_sync;
	logic [1:0] sclk_sync;
	logic [1:0] data_sync;
	logic nss_prev;
	logic sclk_prev;
	logic nss_rise;
	logic nss_fall;
	logic sclk_rise;
	logic [synth_pkg::SAMPLE_WIDTH-1:0] shift_reg;
	logic [COUNT_WIDTH-1:0] bit_count;

	assign nss_rise = nss_sync[1] & ~nss_prev;
	assign nss_fall = ~nss_sync[1] & nss_prev;
	// Only clock edges inside a selected frame count
	assign sclk_rise = sclk_sync[1] & ~sclk_prev & ~nss_sync[1];

	always_ff @(posedge adc_data_received or posedge reset) begin
		if (reset) begin
			// Bus idles with nss high
			nss_sync <= 2'b11;
			nss_prev <= 1'b1;
			sclk_sync <= 2'b00;
			sclk_prev <= 1'b0;
			bit_count <= '0;
			frequency <= synth_pkg::SAMPLE_WIDTH'(DEFAULT_FREQUENCY);
			frequency_valid <= 1'b0;
		end else begin
			nss_sync <= {nss_sync[0], adc_spi_nss};
			sclk_sync <= {sclk_sync[0], adc_spi_clock};
			nss_prev <= nss_sync[1];
			sclk_prev <= sclk_sync[1];
			frequency_valid <= 1'b0;

			// New frame starts the count over
			if (nss_fall) begin
				bit_count <= '0;
			end else if (sclk_rise && bit_count != '1) begin
				// Saturate so long frames never alias to 16
				bit_count <= bit_count + 1'b1;
			end

			// Publish complete 16 bit words only
			if (nss_rise && bit_count == COUNT_WIDTH'(synth_pkg::SAMPLE_WIDTH)) begin
				frequency <= shift_reg;
				frequency_valid <= 1'b1;
			end
		end
	end

	// MSB first shift
	always_ff @(posedge adc_data_received) begin
		data_sync <= {data_sync[0], adc_spi_data};
		if (sclk_rise) begin
			shift_reg <= {shift_reg[synth_pkg::SAMPLE_WIDTH-2:0], data_sync[1]};
		end
	end

	// A frame end yields at most one strobe
	assert property (@(posedge adc_data_received) disable iff (reset)
		frequency_valid |=> !frequency_valid);

endmodule

`default_nettype wire

// File: hdl/phase_mem_if.sv
`timescale 1ns/100ps
`default_nettype none

interface phase_mem_if #(
	parameter int ADDR_WIDTH = 2
);

	// One address per harmonic
	logic [ADDR_WIDTH-1:0] addr;
	logic write;
	logic [synth_pkg::SAMPLE_WIDTH-1:0] write_data;
	// Valid one cycle after addr
	logic [synth_pkg::SAMPLE_WIDTH-1:0] read_data;

	// Sequencer side
	modport controller (
		output addr,
		output write,
		output write_data,
		input read_data
	);

	// RAM side
	modport memory (
		input addr,
		input write,
		input write_data,
		output read_data
	);

endinterface

`default_nettype wire

// File: hdl/synth_pkg.sv
`default_nettype none

package synth_pkg;

	// DAC command byte, write and update channel A
	localparam logic [7:0] DAC_CMD_CHANNEL_A = 8'h31;

	// Frequency word, stored phase and DAC code share one width
	localparam int SAMPLE_WIDTH = 16;

	// Command byte plus DAC code
	localparam int DAC_FRAME_WIDTH = 24;

	// Harmonic sequencer states
	typedef enum logic [2:0] {
		// Waiting for the first sample period after reset
		IDLE,
		// Phase memory read in flight
		READ_PHASE,
		// Add h times the frequency to the stored phase
		ADVANCE,
		// Subtract the sample rate until the phase is in range
		WRAP,
		// Sine table read in flight
		LOOKUP,
		// Add the sine value to the running sum
		ACCUMULATE,
		// Loop done, hold until the period ends
		WAIT_PERIOD
	} seq_state_t;

endpackage

`default_nettype wire
